// ==== rtl/axi_fifo_bridge.sv ====
`timescale 1ns/1ps

module axi_fifo_bridge #(
    parameter int out_depth_log2 = 5,
    parameter int in_depth_log2  = 5
) (
    input  logic                            s_axi_aclk,
    input  logic                            s_axi_aresetn,
    // AXI write address
    input  logic [axi_fifo_pkg::addr_w-1:0] s_axi_awaddr,
    input  logic [axi_fifo_pkg::id_w-1:0]   s_axi_awid,
    input  logic [7:0]                      s_axi_awlen,    // Burst ends on wlast
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    // AXI write response
    input  logic                            s_axi_bready,
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    output logic [axi_fifo_pkg::id_w-1:0]   s_axi_bid,
    // AXI write data
    input  logic [axi_fifo_pkg::data_w-1:0] s_axi_wdata,
    input  logic                            s_axi_wvalid,
    input  logic                            s_axi_wlast,
    output logic                            s_axi_wready,
    // AXI read address
    input  logic [7:0]                      s_axi_arlen,
    input  logic [axi_fifo_pkg::addr_w-1:0] s_axi_araddr,
    input  logic                            s_axi_arvalid,
    input  logic [axi_fifo_pkg::id_w-1:0]   s_axi_arid,
    output logic                            s_axi_arready,
    // AXI read data
    output logic [axi_fifo_pkg::id_w-1:0]   s_axi_rid,
    input  logic                            s_axi_rready,
    output logic [axi_fifo_pkg::data_w-1:0] s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    output logic                            s_axi_rlast,
    // Outbound core
    output logic                            rto_core_reset,
    output logic                            rto_core_flush,
    output logic                            rto_core_write,
    output logic [axi_fifo_pkg::data_w-1:0] rto_core_fifo_din,
    input  logic                            rto_core_full,
    input  logic                            rto_core_empty,
    // Inbound core, first-word-fall-through
    output logic                            rti_core_reset,
    output logic                            rti_core_rd_en,
    output logic                            rti_core_flush,
    input  logic [axi_fifo_pkg::data_w-1:0] rti_core_fifo_dout,
    input  logic                            rti_core_full,
    input  logic                            rti_core_empty
);

    fifo_wr_if out_wr();
    fifo_rd_if out_rd();
    fifo_wr_if in_wr();
    fifo_rd_if in_rd();

    axi_fifo_pkg::wdata_u w_word;
    logic                 in_flush;

    assign w_word.payload = s_axi_wdata;

    //////////////////////////////////////////////////////////////////////
    // Outbound drain and inbound fill
    //////////////////////////////////////////////////////////////////////
    assign rto_core_write    = ~out_rd.empty & ~rto_core_full;
    assign rto_core_fifo_din = out_rd.dout;
    assign out_rd.pop        = rto_core_write;
    assign out_rd.flush      = 1'b0;    // Cleared from the decoder side

    assign rti_core_rd_en = ~rti_core_empty & ~in_wr.full;
    assign in_wr.push     = rti_core_rd_en;
    assign in_wr.din      = rti_core_fifo_dout;   // FWFT head word
    assign in_wr.flush    = in_flush;

    //////////////////////////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////////////////////////
    axi_write_decoder u_write_decoder (
        .s_axi_aclk     (s_axi_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .awaddr         (s_axi_awaddr),
        .awid           (s_axi_awid),
        .awvalid        (s_axi_awvalid),
        .awready        (s_axi_awready),
        .wdata          (w_word),
        .wlast          (s_axi_wlast),
        .wvalid         (s_axi_wvalid),
        .wready         (s_axi_wready),
        .bresp          (s_axi_bresp),
        .bid            (s_axi_bid),
        .bvalid         (s_axi_bvalid),
        .bready         (s_axi_bready),
        .out_fifo       (out_wr.producer),
        .in_flush       (in_flush),
        .rto_core_flush (rto_core_flush),
        .rti_core_flush (rti_core_flush),
        .rto_core_reset (rto_core_reset),
        .rti_core_reset (rti_core_reset)
    );

    sync_fifo #(.depth_log2(out_depth_log2)) u_out_fifo (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wr            (out_wr.fifo),
        .rd            (out_rd.fifo)
    );

    sync_fifo #(.depth_log2(in_depth_log2)) u_in_fifo (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wr            (in_wr.fifo),
        .rd            (in_rd.fifo)
    );

    axi_read_engine u_read_engine (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .araddr        (s_axi_araddr),
        .arid          (s_axi_arid),
        .arlen         (s_axi_arlen),
        .arvalid       (s_axi_arvalid),
        .arready       (s_axi_arready),
        .rdata         (s_axi_rdata),
        .rresp         (s_axi_rresp),
        .rid           (s_axi_rid),
        .rlast         (s_axi_rlast),
        .rvalid        (s_axi_rvalid),
        .rready        (s_axi_rready),
        .in_fifo       (in_rd.consumer)
    );

endmodule

// ==== rtl/axi_fifo_pkg.sv ====
package axi_fifo_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////
    localparam int data_w = 128;            // AXI and core word
    localparam int addr_w = 6;
    localparam int id_w   = 16;

    //////////////////////////////////////////////////////////////////////
    // Address map and responses
    //////////////////////////////////////////////////////////////////////
    localparam logic [addr_w-1:0] addr_fifo = 6'h00;    // Outbound push, inbound pop
    localparam logic [addr_w-1:0] addr_ctrl = 6'h10;    // Flush write, status read

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Control word written to addr_ctrl
    typedef struct packed {
        logic [data_w-3:0] reserved;
        logic              flush_in;        // Empty the inbound path
        logic              flush_out;       // Empty the outbound path
    } flush_cmd_t;

    // One W beat seen either as FIFO data or as a flush command
    typedef union packed {
        logic [data_w-1:0] payload;
        flush_cmd_t        cmd;
    } wdata_u;

endpackage

// ==== rtl/axi_read_engine.sv ====
`timescale 1ns/1ps

module axi_read_engine (
    input  logic                            s_axi_aclk,
    input  logic                            s_axi_aresetn,
    // AR channel
    input  logic [axi_fifo_pkg::addr_w-1:0] araddr,
    input  logic [axi_fifo_pkg::id_w-1:0]   arid,
    input  logic [7:0]                      arlen,
    input  logic                            arvalid,
    output logic                            arready,
    // R channel
    output logic [axi_fifo_pkg::data_w-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic [axi_fifo_pkg::id_w-1:0]   rid,
    output logic                            rlast,
    output logic                            rvalid,
    input  logic                            rready,
    // Inbound FIFO
    fifo_rd_if.consumer                     in_fifo
);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_burst  = 2'd1;   // Beats straight from the FIFO head
    localparam logic [1:0] st_single = 2'd2;   // Status, error or empty reply

    logic [1:0]                      state;
    logic [axi_fifo_pkg::id_w-1:0]   rid_q;
    logic [7:0]                      beat_cnt;      // Beats left after this one
    logic [axi_fifo_pkg::data_w-1:0] single_data;
    logic [1:0]                      single_resp;
    logic                            ar_hs;
    logic                            pop;

    assign arready = (state == st_idle);
    assign ar_hs   = arvalid & arready;
    assign pop     = (state == st_burst) & ~in_fifo.empty & rready;

    assign in_fifo.pop   = pop;
    assign in_fifo.flush = 1'b0;      // Inbound flush enters on the push side

    //////////////////////////////////////////////////////////////////////
    // R channel outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rid = rid_q;
        if (state == st_burst) begin
            rvalid = ~in_fifo.empty;      // Stalls while the core is behind
            rdata  = in_fifo.dout;
            rresp  = axi_fifo_pkg::resp_okay;
            rlast  = (beat_cnt == 8'd0);
        end else begin
            rvalid = (state == st_single);
            rdata  = single_data;
            rresp  = single_resp;
            rlast  = 1'b1;                // Single replies are one beat
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (ar_hs) begin
                        if (araddr == axi_fifo_pkg::addr_fifo && !in_fifo.empty) begin
                            state <= st_burst;
                        end else begin
                            state <= st_single;
                        end
                    end
                end
                st_burst: begin
                    if (pop && beat_cnt == 8'd0) begin
                        state <= st_idle;     // Last beat taken
                    end
                end
                default: begin               // st_single
                    if (rready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Request fields and the registered single reply
    always_ff @(posedge s_axi_aclk) begin
        if (ar_hs) begin
            rid_q    <= arid;
            beat_cnt <= arlen;
            if (araddr == axi_fifo_pkg::addr_ctrl) begin
                single_data <= {{(axi_fifo_pkg::data_w-1){1'b0}}, ~in_fifo.empty};
                single_resp <= axi_fifo_pkg::resp_okay;
            end else begin
                single_data <= '0;       // Empty FIFO read or bad address
                single_resp <= axi_fifo_pkg::resp_slverr;
            end
        end else if (pop) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

endmodule

// ==== rtl/axi_write_decoder.sv ====
`timescale 1ns/1ps

module axi_write_decoder (
    input  logic                            s_axi_aclk,
    input  logic                            s_axi_aresetn,
    // AW channel
    input  logic [axi_fifo_pkg::addr_w-1:0] awaddr,
    input  logic [axi_fifo_pkg::id_w-1:0]   awid,
    input  logic                            awvalid,
    output logic                            awready,
    // W channel
    input  axi_fifo_pkg::wdata_u            wdata,
    input  logic                            wlast,
    input  logic                            wvalid,
    output logic                            wready,
    // B channel
    output logic [1:0]                      bresp,
    output logic [axi_fifo_pkg::id_w-1:0]   bid,
    output logic                            bvalid,
    input  logic                            bready,
    // Outbound FIFO and core controls
    fifo_wr_if.producer                     out_fifo,
    output logic                            in_flush,
    output logic                            rto_core_flush,
    output logic                            rti_core_flush,
    output logic                            rto_core_reset,
    output logic                            rti_core_reset
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_data = 2'd1;     // Beats go to the outbound FIFO
    localparam logic [1:0] st_ctrl = 2'd2;     // Flush commands or bad address
    localparam logic [1:0] st_resp = 2'd3;

    logic [1:0]                    state;
    logic [axi_fifo_pkg::id_w-1:0] awid_q;
    logic                          bad;         // Address outside the map
    logic                          core_reset;
    logic                          aw_hs;
    logic                          w_hs;

    //////////////////////////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////////////////////////
    assign awready = (state == st_idle);
    assign wready  = ((state == st_data) && !out_fifo.full) || (state == st_ctrl);
    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;

    assign bvalid = (state == st_resp);     // Held until bready
    assign bresp  = bad ? axi_fifo_pkg::resp_slverr : axi_fifo_pkg::resp_okay;
    assign bid    = awid_q;

    // Data beats straight into the FIFO
    assign out_fifo.push  = (state == st_data) & w_hs;
    assign out_fifo.din   = wdata.payload;
    assign out_fifo.flush = rto_core_flush;   // Same cycle as the core pulse
    assign in_flush       = rti_core_flush;

    assign rto_core_reset = core_reset;
    assign rti_core_reset = core_reset;

    //////////////////////////////////////////////////////////////////////
    // Write FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state          <= st_idle;
            bad            <= 1'b0;
            rto_core_flush <= 1'b0;
            rti_core_flush <= 1'b0;
        end else begin
            rto_core_flush <= 1'b0;     // Single-cycle pulses
            rti_core_flush <= 1'b0;
            case (state)
                st_idle: begin
                    if (aw_hs) begin
                        bad <= (awaddr != axi_fifo_pkg::addr_fifo) &&
                               (awaddr != axi_fifo_pkg::addr_ctrl);
                        // Bad address still drains its beats in st_ctrl
                        state <= (awaddr == axi_fifo_pkg::addr_fifo) ? st_data : st_ctrl;
                    end
                end
                st_data: begin
                    if (w_hs && wlast) begin
                        state <= st_resp;
                    end
                end
                st_ctrl: begin
                    if (w_hs && !bad) begin
                        rto_core_flush <= wdata.cmd.flush_out;
                        rti_core_flush <= wdata.cmd.flush_in;
                    end
                    if (w_hs && wlast) begin
                        state <= st_resp;
                    end
                end
                default: begin          // st_resp
                    if (bready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Request ID echoed on B
    always_ff @(posedge s_axi_aclk) begin
        if (aw_hs) begin
            awid_q <= awid;
        end
    end

    // Core reset follows the bus reset and releases one cycle late
    always_ff @(posedge s_axi_aclk) begin
        core_reset <= !s_axi_aresetn;
    end

endmodule

// ==== rtl/fifo_rd_if.sv ====
`timescale 1ns/1ps

// Pop side of a show-ahead sync FIFO
interface fifo_rd_if;

    logic                            pop;
    logic [axi_fifo_pkg::data_w-1:0] dout;     // Head word while not empty
    logic                            empty;
    logic                            flush;

    modport consumer (
        output pop,
        output flush,
        input  dout,
        input  empty
    );

    modport fifo (
        input  pop,
        input  flush,
        output dout,
        output empty
    );

endinterface

// ==== rtl/fifo_wr_if.sv ====
`timescale 1ns/1ps

// Push side of a sync FIFO
interface fifo_wr_if;

    logic                            push;
    logic [axi_fifo_pkg::data_w-1:0] din;
    logic                            full;
    logic                            flush;     // One-cycle clear that wins over a push

    modport producer (
        output push,
        output din,
        output flush,
        input  full
    );

    modport fifo (
        input  push,
        input  din,
        input  flush,
        output full
    );

endinterface

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int depth_log2 = 5
) (
    input  logic      s_axi_aclk,
    input  logic      s_axi_aresetn,
    fifo_wr_if.fifo   wr,
    fifo_rd_if.fifo   rd
);

    logic [axi_fifo_pkg::data_w-1:0] mem [0:(1 << depth_log2)-1];
    logic [depth_log2-1:0] wr_ptr;
    logic [depth_log2-1:0] rd_ptr;
    logic [depth_log2:0]   count;       // One bit wider than the pointers

    logic flush;
    logic do_push;
    logic do_pop;

    assign flush   = wr.flush | rd.flush;           // Either side may clear
    assign do_push = wr.push & ~wr.full & ~flush;   // Flush wins
    assign do_pop  = rd.pop & ~rd.empty;

    assign wr.full  = count[depth_log2];   // MSB only set at full depth
    assign rd.empty = (count == '0);
    assign rd.dout  = mem[rd_ptr];          // Show-ahead head word

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge s_axi_aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.din;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_fifo_bridge \
    -f tb.f \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

// ==== tb.f ====
rtl/axi_fifo_pkg.sv
rtl/fifo_wr_if.sv
rtl/fifo_rd_if.sv
rtl/sync_fifo.sv
rtl/axi_write_decoder.sv
rtl/axi_read_engine.sv
rtl/axi_fifo_bridge.sv
verif/tb_axi_fifo_bridge.sv

// ==== verif/tb_axi_fifo_bridge.sv ====
`timescale 1ns/1ps

module tb_axi_fifo_bridge;

    // Five tests need a few hundred cycles in total
    localparam int max_cycles = 4000;
    localparam int dw = axi_fifo_pkg::data_w;

    //////////////////////////////////////////////////////////////////////
    // DUT ports
    //////////////////////////////////////////////////////////////////////
    logic          s_axi_aclk = 1'b0;
    logic          s_axi_aresetn;
    logic [5:0]    s_axi_awaddr, s_axi_araddr;
    logic [15:0]   s_axi_awid, s_axi_arid, s_axi_bid, s_axi_rid;
    logic [7:0]    s_axi_awlen, s_axi_arlen;
    logic          s_axi_awvalid, s_axi_awready, s_axi_arvalid, s_axi_arready;
    logic [dw-1:0] s_axi_wdata, s_axi_rdata;
    logic          s_axi_wvalid, s_axi_wlast, s_axi_wready;
    logic          s_axi_bready, s_axi_bvalid;
    logic [1:0]    s_axi_bresp, s_axi_rresp;
    logic          s_axi_rready = 1'b1;
    logic          s_axi_rvalid, s_axi_rlast;
    logic          rto_core_reset, rto_core_flush, rto_core_write, rto_core_empty;
    logic [dw-1:0] rto_core_fifo_din;
    logic          rto_core_full = 1'b0;
    logic          rti_core_reset, rti_core_flush, rti_core_rd_en, rti_core_full;
    logic [dw-1:0] rti_core_fifo_dout = '0;
    logic          rti_core_empty = 1'b1;

    axi_fifo_bridge DUT (.*);

    // Test state
    logic [dw-1:0] rto_q[$];            // Words seen by the outbound core
    logic [dw-1:0] rti_q[$];            // Words waiting in the inbound core
    logic [dw-1:0] wbuf[0:7];
    logic [dw-1:0] rbuf[0:15];
    logic [1:0]    rresp_buf[0:15];
    logic [15:0]   rid_buf[0:15];
    logic          rlast_buf[0:15];
    logic [31:0]   data_rng = 32'he6f3_b98d;
    logic [31:0]   stall_rng = 32'he6f3_b98d ^ 32'h9e37_79b9;   // Separate stream for stalls
    logic          full_rand = 1'b0;
    logic          full_hold = 1'b0;
    logic          rready_rand = 1'b0;
    int            err_count = 0;
    int            check_count = 0;
    int            cycle_cnt = 0;
    int            rto_flush_cnt = 0;
    int            rti_flush_cnt = 0;

    always #4 s_axi_aclk = ~s_axi_aclk;     // 8 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [dw-1:0] rand_word();
        logic [dw-1:0] w;
        for (int i = 0; i < dw / 32; i++) begin
            data_rng = xorshift(data_rng);
            w[i*32 +: 32] = data_rng;
        end
        return w;
    endfunction

    task automatic check(input bit ok, input string what);
        check_count++;
        assert (ok) else begin
            err_count++;
            $display("ERROR at %0d ns: %s", $time, what);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Core models, stalls and watchdog
    //////////////////////////////////////////////////////////////////////
    always @(negedge s_axi_aclk) begin
        stall_rng     <= xorshift(stall_rng);
        rto_core_full <= full_hold | (full_rand & stall_rng[7]);
        s_axi_rready  <= ~rready_rand | stall_rng[12];
        rti_core_empty     <= (rti_q.size() == 0);      // FWFT head shown while not empty
        rti_core_fifo_dout <= (rti_q.size() == 0) ? '0 : rti_q[0];
    end

    always @(posedge s_axi_aclk) begin
        if (s_axi_aresetn && rto_core_write) begin
            check(!rto_core_full, "rto_core_write while rto_core_full is high");
            rto_q.push_back(rto_core_fifo_din);
        end
        if (rti_core_rd_en) begin
            void'(rti_q.pop_front());       // Core hands over its head word
        end
        if (rto_core_flush === 1'b1) begin
            rto_flush_cnt++;
        end
        if (rti_core_flush === 1'b1) begin
            rti_flush_cnt++;
        end
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout: run did not finish in %0d cycles, %0d errors", cycle_cnt, err_count);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // AXI master tasks
    //////////////////////////////////////////////////////////////////////
    task automatic axi_write(input logic [5:0] addr, input logic [15:0] id, input int n,
                             output logic [1:0] resp, output logic [15:0] id_got);
        @(negedge s_axi_aclk);
        s_axi_awaddr  = addr;
        s_axi_awid    = id;
        s_axi_awlen   = 8'(n - 1);
        s_axi_awvalid = 1'b1;
        @(posedge s_axi_aclk);
        while (!s_axi_awready) @(posedge s_axi_aclk);
        for (int i = 0; i < n; i++) begin
            @(negedge s_axi_aclk);
            s_axi_awvalid = 1'b0;
            s_axi_wdata   = wbuf[i];
            s_axi_wlast   = (i == n - 1);
            s_axi_wvalid  = 1'b1;
            @(posedge s_axi_aclk);
            while (!s_axi_wready) @(posedge s_axi_aclk);   // FIFO back-pressure
        end
        @(negedge s_axi_aclk);
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
        s_axi_bready = 1'b1;
        @(posedge s_axi_aclk);
        while (!s_axi_bvalid) @(posedge s_axi_aclk);
        resp   = s_axi_bresp;
        id_got = s_axi_bid;
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
    endtask

    // Collects beats up to rlast into the r*_buf arrays
    task automatic axi_read(input logic [5:0] addr, input logic [15:0] id,
                            input logic [7:0] len, output int n);
        bit done;
        n    = 0;
        done = 1'b0;
        @(negedge s_axi_aclk);
        s_axi_araddr  = addr;
        s_axi_arid    = id;
        s_axi_arlen   = len;
        s_axi_arvalid = 1'b1;
        @(posedge s_axi_aclk);
        while (!s_axi_arready) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        while (!done) begin
            @(posedge s_axi_aclk);
            if (s_axi_rvalid && s_axi_rready) begin
                rbuf[n]      = s_axi_rdata;
                rresp_buf[n] = s_axi_rresp;
                rid_buf[n]   = s_axi_rid;
                rlast_buf[n] = s_axi_rlast;
                done = s_axi_rlast || (n == 15);    // Guard against a missing rlast
                n++;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    task automatic apply_reset();
        s_axi_aresetn = 1'b0;
        repeat (4) @(negedge s_axi_aclk);
        check(rto_core_reset === 1'b1 && rti_core_reset === 1'b1, "core resets low during reset");
        s_axi_aresetn = 1'b1;
        repeat (2) @(negedge s_axi_aclk);
        check(rto_core_reset === 1'b0 && rti_core_reset === 1'b0, "core resets high after reset");
        check(s_axi_awready && s_axi_arready && !s_axi_wready && !s_axi_bvalid && !s_axi_rvalid,
              "AXI ready/valid levels wrong after reset");
    endtask

    task automatic write_outbound_burst();
        logic [1:0]  resp;
        logic [15:0] id;
        for (int i = 0; i < 8; i++) begin
            wbuf[i] = rand_word();
        end
        full_rand = 1'b1;                   // Core full toggles during the burst
        axi_write(axi_fifo_pkg::addr_fifo, 16'h1234, 8, resp, id);
        while (rto_q.size() < 8) @(posedge s_axi_aclk);
        full_rand = 1'b0;
        repeat (4) @(posedge s_axi_aclk);   // Room for a stray extra word to show up
        check(rto_q.size() == 8, $sformatf("rto got %0d words, expected 8", rto_q.size()));
        for (int i = 0; i < 8; i++) begin
            check(rto_q[i] == wbuf[i], $sformatf("rto word %0d is %h, expected %h",
                                                 i, rto_q[i], wbuf[i]));
        end
        check(resp == axi_fifo_pkg::resp_okay, $sformatf("bresp %0d, expected OKAY", resp));
        check(id == 16'h1234, $sformatf("bid %h, expected 1234", id));
    endtask

    task automatic read_inbound_burst();
        logic [dw-1:0] exp[0:3];
        int            n;
        for (int i = 0; i < 4; i++) begin
            exp[i] = rand_word();
            rti_q.push_back(exp[i]);
        end
        while (rti_q.size() != 0) @(posedge s_axi_aclk);
        axi_read(axi_fifo_pkg::addr_ctrl, 16'h0077, 8'd0, n);
        check(n == 1 && rbuf[0][0] == 1'b1, "status read does not show inbound data");
        rready_rand = 1'b1;
        axi_read(axi_fifo_pkg::addr_fifo, 16'h0055, 8'd3, n);
        rready_rand = 1'b0;
        check(n == 4, $sformatf("burst gave %0d beats, expected 4", n));
        for (int i = 0; i < 4; i++) begin
            check(rbuf[i] == exp[i], $sformatf("beat %0d is %h, expected %h", i, rbuf[i], exp[i]));
            check(rresp_buf[i] == axi_fifo_pkg::resp_okay && rid_buf[i] == 16'h0055,
                  $sformatf("beat %0d rresp %0d rid %h", i, rresp_buf[i], rid_buf[i]));
            check(rlast_buf[i] == (i == 3), $sformatf("rlast wrong on beat %0d", i));
        end
    endtask

    task automatic read_when_empty();
        int n;
        axi_read(axi_fifo_pkg::addr_ctrl, 16'h0101, 8'd0, n);
        check(n == 1 && rbuf[0] == '0 && rresp_buf[0] == axi_fifo_pkg::resp_okay,
              $sformatf("empty status read gave %h, rresp %0d", rbuf[0], rresp_buf[0]));
        axi_read(axi_fifo_pkg::addr_fifo, 16'h0102, 8'd3, n);
        check(n == 1 && rlast_buf[0] && rresp_buf[0] == axi_fifo_pkg::resp_slverr,
              $sformatf("empty FIFO read gave %0d beats, rresp %0d", n, rresp_buf[0]));
    endtask

    task automatic flush_both_paths();
        logic [1:0]  resp;
        logic [15:0] id;
        int          n;
        int          rto_base;
        full_hold = 1'b1;                   // Outbound words stay in the bridge
        repeat (2) @(posedge s_axi_aclk);
        for (int i = 0; i < 3; i++) begin
            wbuf[i] = rand_word();
            rti_q.push_back(rand_word());
        end
        axi_write(axi_fifo_pkg::addr_fifo, 16'h0040, 3, resp, id);
        while (rti_q.size() != 0) @(posedge s_axi_aclk);
        rto_base      = rto_q.size();
        rto_flush_cnt = 0;
        rti_flush_cnt = 0;
        wbuf[0] = 128'h3;                   // Bit 0 outbound, bit 1 inbound
        axi_write(axi_fifo_pkg::addr_ctrl, 16'h0041, 1, resp, id);
        repeat (2) @(posedge s_axi_aclk);
        check(resp == axi_fifo_pkg::resp_okay, $sformatf("flush bresp %0d", resp));
        check(rto_flush_cnt == 1 && rti_flush_cnt == 1,
              $sformatf("flush pulses rto %0d rti %0d", rto_flush_cnt, rti_flush_cnt));
        axi_read(axi_fifo_pkg::addr_ctrl, 16'h0042, 8'd0, n);
        check(n == 1 && rbuf[0] == '0, $sformatf("status after flush is %h", rbuf[0]));
        full_hold = 1'b0;
        repeat (20) @(posedge s_axi_aclk);
        check(rto_q.size() == rto_base, "rto_core_write after outbound flush");
    endtask

    task automatic access_bad_address();
        logic [1:0]  resp;
        logic [15:0] id;
        int          n;
        int          rto_base;
        rto_base = rto_q.size();
        wbuf[0]  = rand_word();
        wbuf[1]  = rand_word();
        rti_q.push_back(rand_word());       // Inbound data waiting, so a bad read must not burst
        axi_write(6'h08, 16'hbad1, 2, resp, id);
        check(resp == axi_fifo_pkg::resp_slverr && id == 16'hbad1,
              $sformatf("bad write bresp %0d bid %h", resp, id));
        while (rti_q.size() != 0) @(posedge s_axi_aclk);
        axi_read(6'h08, 16'h0bad, 8'd1, n);
        check(n == 1 && rresp_buf[0] == axi_fifo_pkg::resp_slverr && rid_buf[0] == 16'h0bad,
              $sformatf("bad read %0d beats rresp %0d rid %h", n, rresp_buf[0], rid_buf[0]));
        repeat (4) @(posedge s_axi_aclk);
        check(rto_q.size() == rto_base, "rto_core_write after write to bad address");
    endtask

    initial begin
        s_axi_awaddr   = '0;
        s_axi_awid     = '0;
        s_axi_awlen    = '0;
        s_axi_awvalid  = 1'b0;
        s_axi_wdata    = '0;
        s_axi_wvalid   = 1'b0;
        s_axi_wlast    = 1'b0;
        s_axi_bready   = 1'b0;
        s_axi_araddr   = '0;
        s_axi_arid     = '0;
        s_axi_arlen    = '0;
        s_axi_arvalid  = 1'b0;
        rto_core_empty = 1'b1;
        rti_core_full  = 1'b0;
        apply_reset();
        write_outbound_burst();
        read_inbound_burst();
        read_when_empty();
        flush_both_paths();
        access_bad_address();
        $display("Run complete: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
